//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build dcache_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f build.f -o Vdcache_tb
	./obj_dir/Vdcache_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "test failed, run ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
common/cache_geom_pkg.sv
common/mem_bus_pkg.sv
common/cache_array_if.sv
dcache/dcache_array.sv
dcache/dcache_lookup.sv
dcache/dcache_ctrl.sv
hdl/dcache.sv
verif/dcache_tb.sv

//--- common/cache_array_if.sv
/*
 Array access interface: index, way and write controls from the
 controller, per-way contents of the addressed set back from storage.
*/

interface cache_array_if
   import cache_geom_pkg::*;
   import mem_bus_pkg::*;
#(
   parameter int IDX_W = DEF_IDX_W
);
   localparam int TAG_W = WORD_W - IDX_W - BLK_OFF_W - BYTE_OFF_W;

   logic [IDX_W-1:0]                       idx;
   way_t                                   way;
   logic [BLK_OFF_W-1:0]                   word_sel;
   word_t                                  wdata;
   logic [TAG_W-1:0]                       wtag;      // tag loaded on fill
   logic                                   wr_word;
   logic                                   wr_tag;
   logic                                   set_dirty;
   logic                                   clr_valid;
   logic                                   touch;     // lru update

   logic [NUM_WAYS-1:0][TAG_W-1:0]         tag_out;
   logic [NUM_WAYS-1:0]                    valid_out;
   logic [NUM_WAYS-1:0]                    dirty_out;
   word_t [NUM_WAYS-1:0][BLK_WORDS-1:0]    data_out;
   logic                                   lru_out;

   modport ctrl (
      output idx, way, word_sel, wdata, wtag, wr_word, wr_tag, set_dirty, clr_valid, touch,
      input  tag_out, valid_out, dirty_out, data_out, lru_out
   );

   modport store (
      input  idx, way, word_sel, wdata, wtag, wr_word, wr_tag, set_dirty, clr_valid, touch,
      output tag_out, valid_out, dirty_out, data_out, lru_out
   );

   modport look (
      input tag_out, valid_out, dirty_out, data_out, lru_out
   );

endinterface

//--- common/cache_geom_pkg.sv
/*
 Address geometry of the two-way data cache: word, offset and way
 widths, the default index width and the packed address breakdown.
*/

package cache_geom_pkg;

   localparam int WORD_W     = 32;
   localparam int BYTE_OFF_W = 2;
   localparam int BLK_OFF_W  = 1;           // two words per block
   localparam int BLK_WORDS  = 2 ** BLK_OFF_W;
   localparam int NUM_WAYS   = 2;

   // default set count is 2**DEF_IDX_W
   localparam int DEF_IDX_W  = 3;
   localparam int DEF_TAG_W  = WORD_W - DEF_IDX_W - BLK_OFF_W - BYTE_OFF_W;

   typedef logic way_t;                     // one bit for two ways

   // field split for the default geometry
   typedef struct packed
   {
      logic [DEF_TAG_W-1:0]  tag;
      logic [DEF_IDX_W-1:0]  idx;
      logic [BLK_OFF_W-1:0]  blkoff;
      logic [BYTE_OFF_W-1:0] bytoff;
   } dcache_addr_t;

endpackage

//--- common/mem_bus_pkg.sv
/*
 Data word, array write-port commands and controller state encoding
 for the data cache.
*/

package mem_bus_pkg;

   typedef logic [cache_geom_pkg::WORD_W-1:0] word_t;

   // write-port commands toward the storage arrays
   typedef struct packed
   {
      logic wr_word;                        // single word, e.g. store hit
      logic wr_fill;                        // fill word, also loads tag
      logic clr_valid;                      // invalidate entry
   } line_write_t;

   typedef enum logic [3:0]
   {
      idle,
      wback1,
      wback2,
      fill1,
      fill2,
      flush1,
      flush2,
      halted
   } ctrl_state_t;

endpackage

//--- dcache/dcache_array.sv
/*
 Tag, valid, dirty, data and LRU storage for the data cache.
 Combinational read of the addressed set, one write port.
*/

module dcache_array
   import cache_geom_pkg::*;
   import mem_bus_pkg::*;
#(
   parameter int IDX_W = DEF_IDX_W
)
(
   input logic          CLK,
   input logic          nRST,
   cache_array_if.store arr
);
   localparam int SETS  = 2 ** IDX_W;
   localparam int TAG_W = WORD_W - IDX_W - BLK_OFF_W - BYTE_OFF_W;

   logic [TAG_W-1:0]    tag_mem  [SETS][NUM_WAYS];
   word_t               data_mem [SETS][NUM_WAYS][BLK_WORDS];
   logic [NUM_WAYS-1:0] valid    [SETS];
   logic [NUM_WAYS-1:0] dirty    [SETS];
   logic                lru      [SETS];   // way to replace next

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int s = 0; s < SETS; s++)
         begin
            valid[s] <= '0;
            dirty[s] <= '0;
            lru[s]   <= 1'b0;
         end
      end
      else
      begin
         if (arr.clr_valid)
         begin
            valid[arr.idx][arr.way] <= 1'b0;
            dirty[arr.idx][arr.way] <= 1'b0;
         end
         else
         begin
            if (arr.wr_tag)
               valid[arr.idx][arr.way] <= 1'b1;
            if (arr.set_dirty)
               dirty[arr.idx][arr.way] <= 1'b1;
            else if (arr.wr_tag)
               dirty[arr.idx][arr.way] <= 1'b0;   // fresh block from memory
         end
         if (arr.touch)
            lru[arr.idx] <= ~arr.way;             // other way now oldest
      end
   end

   always_ff @(posedge CLK)
   begin
      if (arr.wr_tag)
         tag_mem[arr.idx][arr.way] <= arr.wtag;
      if (arr.wr_word)
         data_mem[arr.idx][arr.way][arr.word_sel] <= arr.wdata;
   end

   always_comb
   begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         arr.tag_out[w]   = tag_mem[arr.idx][w];
         arr.valid_out[w] = valid[arr.idx][w];
         arr.dirty_out[w] = dirty[arr.idx][w];
         for (int k = 0; k < BLK_WORDS; k++)
            arr.data_out[w][k] = data_mem[arr.idx][w][k];
      end
      arr.lru_out = lru[arr.idx];
   end

   // a store hit may only mark a block that is resident
   a_dirty_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
      arr.set_dirty |-> (valid[arr.idx][arr.way] || arr.wr_tag))
      else $error("set_dirty on invalid entry without fill");

endmodule

//--- dcache/dcache_ctrl.sv
/*
 Data cache controller: hit response, dirty victim write-back,
 two-word fill, flush walk on halt and memory request driving.
*/

module dcache_ctrl
   import cache_geom_pkg::*;
   import mem_bus_pkg::*;
#(
   parameter int IDX_W = DEF_IDX_W
)
(
   input  logic         CLK,
   input  logic         nRST,
   input  logic         mem_ren,
   input  logic         mem_wen,
   input  logic         halt,
   input  logic         mem_wait,
   input  dcache_addr_t mem_addr,
   input  word_t        mem_store,
   input  word_t        rd_data,
   input  logic         tag_hit,
   input  way_t         hit_way,
   input  way_t         victim_way,
   input  logic         victim_dirty,
   input  word_t        hit_word,
   output logic         hit,
   output logic         flushed,
   output logic         mem_rd,
   output logic         mem_wr,
   output word_t        load,
   output word_t        mem_req_addr,
   output word_t        wr_data,
   cache_array_if.ctrl  arr
);
   localparam int TAG_W = WORD_W - IDX_W - BLK_OFF_W - BYTE_OFF_W;

   ctrl_state_t          state;
   ctrl_state_t          next_state;
   way_t                 vway;           // way chosen at the miss
   logic [IDX_W:0]       flush_pos;      // {set, way}
   logic                 flush_step;
   logic [WORD_W-1:0]    req_bits;
   logic [TAG_W-1:0]     req_tag;
   logic [IDX_W-1:0]     req_idx;
   logic [BLK_OFF_W-1:0] req_blk;
   logic [IDX_W-1:0]     line_idx;
   way_t                 wb_way;
   logic [BLK_OFF_W-1:0] wb_word;
   word_t                wb_addr;
   logic                 flushing;
   logic                 flush_dirty;
   line_write_t          cmd;

   assign req_bits = mem_addr;
   assign req_tag  = req_bits[WORD_W-1 -: TAG_W];
   assign req_idx  = req_bits[BYTE_OFF_W + BLK_OFF_W +: IDX_W];
   assign req_blk  = mem_addr.blkoff;

   assign flushing    = (state == flush1) || (state == flush2);
   assign line_idx    = flushing ? flush_pos[IDX_W:1] : req_idx;
   assign wb_way      = flushing ? flush_pos[0] : vway;
   assign wb_word     = ((state == wback2) || (state == flush2)) ? 1'b1 : 1'b0;
   assign wb_addr     = {arr.tag_out[wb_way], line_idx, wb_word, {BYTE_OFF_W{1'b0}}};
   assign flush_dirty = arr.valid_out[wb_way] & arr.dirty_out[wb_way];

   assign arr.idx       = line_idx;
   assign arr.wtag      = req_tag;
   assign arr.wr_word   = cmd.wr_word | cmd.wr_fill;
   assign arr.wr_tag    = cmd.wr_fill;
   assign arr.clr_valid = cmd.clr_valid;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state     <= idle;
         vway      <= 1'b0;
         flush_pos <= '0;
      end
      else
      begin
         state <= next_state;
         if (state == idle)
         begin
            vway      <= victim_way;
            flush_pos <= '0;
         end
         else if (flush_step)
            flush_pos <= flush_pos + 1'b1;
      end
   end

   always_comb
   begin
      next_state    = state;
      flush_step    = 1'b0;
      hit           = 1'b0;
      flushed       = 1'b0;
      load          = hit_word;
      mem_rd        = 1'b0;
      mem_wr        = 1'b0;
      mem_req_addr  = '0;
      wr_data       = '0;
      cmd           = '0;
      arr.way       = wb_way;
      arr.word_sel  = wb_word;
      arr.wdata     = rd_data;
      arr.set_dirty = 1'b0;
      arr.touch     = 1'b0;

      case (state)
         idle:
         begin
            if (mem_ren || mem_wen)
            begin
               if (tag_hit)
               begin
                  hit           = 1'b1;
                  arr.way       = hit_way;
                  arr.word_sel  = req_blk;
                  arr.wdata     = mem_store;
                  arr.touch     = 1'b1;
                  cmd.wr_word   = mem_wen;
                  arr.set_dirty = mem_wen;   // clean block turns dirty too
               end
               else if (victim_dirty)
                  next_state = wback1;
               else
                  next_state = fill1;
            end
            else if (halt)
               next_state = flush1;
            else
               hit = 1'b1;
         end
         wback1, wback2:
         begin
            mem_wr       = 1'b1;
            mem_req_addr = wb_addr;
            wr_data      = arr.data_out[wb_way][wb_word];
            if (!mem_wait)
               next_state = (state == wback1) ? wback2 : fill1;
         end
         fill1:
         begin
            mem_rd       = 1'b1;
            mem_req_addr = {req_tag, req_idx, ~req_blk, {BYTE_OFF_W{1'b0}}};   // other word first
            arr.way      = vway;
            arr.word_sel = ~req_blk;
            if (!mem_wait)
            begin
               cmd.wr_fill = 1'b1;
               next_state  = fill2;
            end
         end
         fill2:
         begin
            mem_rd       = 1'b1;
            mem_req_addr = {req_tag, req_idx, req_blk, {BYTE_OFF_W{1'b0}}};
            load         = rd_data;
            arr.way      = vway;
            arr.word_sel = req_blk;
            if (!mem_wait)
            begin
               hit           = 1'b1;
               cmd.wr_fill   = 1'b1;
               arr.touch     = 1'b1;
               arr.set_dirty = mem_wen;
               if (mem_wen)
                  arr.wdata = mem_store;   // store replaces fetched word
               next_state = idle;
            end
         end
         flush1:
         begin
            if (flush_dirty)
            begin
               mem_wr       = 1'b1;
               mem_req_addr = wb_addr;
               wr_data      = arr.data_out[wb_way][wb_word];
               if (!mem_wait)
                  next_state = flush2;
            end
            else
            begin
               cmd.clr_valid = 1'b1;
               flush_step    = 1'b1;
               next_state    = (&flush_pos) ? halted : flush1;
            end
         end
         flush2:
         begin
            mem_wr       = 1'b1;
            mem_req_addr = wb_addr;
            wr_data      = arr.data_out[wb_way][wb_word];
            if (!mem_wait)
            begin
               cmd.clr_valid = 1'b1;
               flush_step    = 1'b1;
               next_state    = (&flush_pos) ? halted : flush1;
            end
         end
         halted:
         begin
            hit     = 1'b1;
            flushed = 1'b1;
         end
         default:
            next_state = idle;
      endcase
   end

   a_one_mem_req: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_rd && mem_wr))
      else $error("mem_rd and mem_wr both high");

   // address held across a stalled transfer
   a_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
      ((mem_rd || mem_wr) && mem_wait) |=> $stable(mem_req_addr))
      else $error("mem_req_addr changed while mem_wait high");

endmodule

//--- dcache/dcache_lookup.sv
/*
 Tag compare over both ways, hit way, victim choice and the
 read word of the hitting way.
*/

module dcache_lookup
   import cache_geom_pkg::*;
   import mem_bus_pkg::*;
#(
   parameter int IDX_W = DEF_IDX_W
)
(
   input  dcache_addr_t       req_addr,
   cache_array_if.look        arr,
   output logic               tag_hit,
   output way_t               hit_way,
   output way_t               victim_way,
   output logic               victim_dirty,
   output word_t              hit_word
);
   localparam int TAG_W = WORD_W - IDX_W - BLK_OFF_W - BYTE_OFF_W;

   logic [WORD_W-1:0]   req_bits;
   logic [TAG_W-1:0]    req_tag;
   logic [NUM_WAYS-1:0] match;

   assign req_bits = req_addr;
   assign req_tag  = req_bits[WORD_W-1 -: TAG_W];   // tag width follows IDX_W

   always_comb
   begin
      for (int w = 0; w < NUM_WAYS; w++)
         match[w] = arr.valid_out[w] && (arr.tag_out[w] == req_tag);
   end

   assign tag_hit  = |match;
   assign hit_way  = match[1];
   assign hit_word = arr.data_out[hit_way][req_addr.blkoff];

   // invalid way first, else the lru way
   always_comb
   begin
      if (!arr.valid_out[0])
         victim_way = 1'b0;
      else if (!arr.valid_out[1])
         victim_way = 1'b1;
      else
         victim_way = arr.lru_out;
   end

   assign victim_dirty = arr.valid_out[victim_way] & arr.dirty_out[victim_way];

   // no clock here, checked at the end of each time step
   always_comb
   begin
      a_unique_tag: assert final (!(&arr.valid_out) || (arr.tag_out[0] != arr.tag_out[1]))
         else $error("both ways hold the same tag");
   end

endmodule

//--- hdl/dcache.sv
/*
 Write-back two-way data cache, top level.
 Storage arrays, tag lookup and miss/flush controller.
*/

module dcache
   import cache_geom_pkg::*;
   import mem_bus_pkg::*;
#(
   parameter int IDX_W = DEF_IDX_W
)
(
   input  logic         CLK,
   input  logic         nRST,
   input  logic         mem_ren,
   input  logic         mem_wen,
   input  logic         halt,
   input  dcache_addr_t mem_addr,
   input  word_t        mem_store,
   input  logic         mem_wait,
   input  word_t        rd_data,
   output logic         hit,
   output logic         flushed,
   output word_t        load,
   output logic         mem_rd,
   output logic         mem_wr,
   output word_t        mem_req_addr,
   output word_t        wr_data
);
   logic  tag_hit;
   way_t  hit_way;
   way_t  victim_way;
   logic  victim_dirty;
   word_t hit_word;

   cache_array_if #(.IDX_W(IDX_W)) arr_if ();

   dcache_array #(.IDX_W(IDX_W)) array_i (
      .CLK  (CLK),
      .nRST (nRST),
      .arr  (arr_if.store)
   );

   dcache_lookup #(.IDX_W(IDX_W)) lookup_i (
      .req_addr     (mem_addr),
      .arr          (arr_if.look),
      .tag_hit      (tag_hit),
      .hit_way      (hit_way),
      .victim_way   (victim_way),
      .victim_dirty (victim_dirty),
      .hit_word     (hit_word)
   );

   dcache_ctrl #(.IDX_W(IDX_W)) ctrl_i (
      .CLK          (CLK),
      .nRST         (nRST),
      .mem_ren      (mem_ren),
      .mem_wen      (mem_wen),
      .halt         (halt),
      .mem_wait     (mem_wait),
      .mem_addr     (mem_addr),
      .mem_store    (mem_store),
      .rd_data      (rd_data),
      .tag_hit      (tag_hit),
      .hit_way      (hit_way),
      .victim_way   (victim_way),
      .victim_dirty (victim_dirty),
      .hit_word     (hit_word),
      .hit          (hit),
      .flushed      (flushed),
      .mem_rd       (mem_rd),
      .mem_wr       (mem_wr),
      .load         (load),
      .mem_req_addr (mem_req_addr),
      .wr_data      (wr_data),
      .arr          (arr_if.ctrl)
   );

endmodule

//--- verif/dcache_tb.sv
/*
 Testbench for the two-way data cache: clock and reset, memory model
 with random wait states, processor stimulus, shadow memory reference,
 compare tasks and watchdog.
*/

module dcache_tb
   import cache_geom_pkg::*;
   import mem_bus_pkg::*;
();
   localparam int IDX_W        = DEF_IDX_W;
   localparam int PERIOD       = 100;
   localparam int MEM_WORDS    = 1024;             // 4 KB modelled
   localparam int MAX_WAIT     = 3;                // extra wait cycles per word
   localparam int N_DIRECTED   = 24;
   localparam int N_RAND       = 200;
   localparam int MISS_CYCLES  = 4 * (MAX_WAIT + 2) + 2;   // two write-backs and two fills
   localparam int FLUSH_CYCLES = 2 * (2 ** IDX_W) * 2 * (MAX_WAIT + 2);
   localparam int WATCHDOG_T   =
      (10 + (N_DIRECTED + N_RAND) * MISS_CYCLES + FLUSH_CYCLES + 100) * PERIOD;
   localparam logic [31:0] SEED = 32'he51e;

   logic         CLK = 1'b0;
   logic         nRST;
   logic         mem_ren;
   logic         mem_wen;
   logic         halt;
   dcache_addr_t mem_addr;
   word_t        mem_store;
   logic         mem_wait;
   word_t        rd_data;
   logic         hit;
   logic         flushed;
   word_t        load;
   logic         mem_rd;
   logic         mem_wr;
   word_t        mem_req_addr;
   word_t        wr_data;

   word_t  mem_model [MEM_WORDS];
   word_t  shadow    [MEM_WORDS];
   bit     written   [MEM_WORDS];
   integer stim_seed = SEED;
   integer wait_seed = SEED;

   dcache #(.IDX_W(IDX_W)) dcache_i (
      .CLK          (CLK),
      .nRST         (nRST),
      .mem_ren      (mem_ren),
      .mem_wen      (mem_wen),
      .halt         (halt),
      .mem_addr     (mem_addr),
      .mem_store    (mem_store),
      .mem_wait     (mem_wait),
      .rd_data      (rd_data),
      .hit          (hit),
      .flushed      (flushed),
      .load         (load),
      .mem_rd       (mem_rd),
      .mem_wr       (mem_wr),
      .mem_req_addr (mem_req_addr),
      .wr_data      (wr_data)
   );

   always #(PERIOD / 2) CLK = ~CLK;

   function automatic word_t init_word(input word_t addr);
      return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
   endfunction

   function automatic int word_index(input word_t addr);
      return int'(addr[11:2]);
   endfunction

   // last processor store, else the initial memory pattern
   function automatic word_t expected_load(input word_t addr);
      if (written[word_index(addr)])
         return shadow[word_index(addr)];
      return init_word({addr[31:2], 2'b00});
   endfunction

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // hold one request until hit, at_once set when served in its first cycle
   task automatic serve_request(input logic wr, input word_t a, input word_t d,
                                output logic at_once);
      int cycles;
      cycles = 0;
      mem_addr  <= a;
      mem_ren   <= !wr;
      mem_wen   <= wr;
      mem_store <= d;
      @(posedge CLK);
      while (!hit)
      begin
         cycles++;
         @(posedge CLK);
      end
      at_once = (cycles == 0);
      mem_ren <= 1'b0;
      mem_wen <= 1'b0;
   endtask

   // memory model, one mandatory wait cycle per word plus random ones
   initial
   begin
      int    wait_cnt;
      word_t rnd;
      wait_cnt = 0;
      mem_wait = 1'b1;
      rd_data  = '0;
      for (int i = 0; i < MEM_WORDS; i++)
         mem_model[i] = init_word(word_t'(i * 4));
      forever
      begin
         @(posedge CLK);
         if ((mem_rd || mem_wr) && (mem_req_addr >= MEM_WORDS * 4 || mem_req_addr[1:0] != '0))
            abort_run($sformatf("memory request to 0x%h lies outside the modelled memory",
                                mem_req_addr));
         if ((mem_rd || mem_wr) && !mem_wait)
         begin
            if (mem_wr)
            begin
               check_word("wr_data", wr_data, expected_load(mem_req_addr));
               mem_model[word_index(mem_req_addr)] = wr_data;
            end
            mem_wait <= 1'b1;
            wait_cnt = 0;
         end
         else if (mem_rd || mem_wr)
         begin
            rnd = $random(wait_seed);
            rd_data  <= mem_model[word_index(mem_req_addr)];
            mem_wait <= (wait_cnt < MAX_WAIT) && rnd[0];
            wait_cnt++;
         end
         else
         begin
            mem_wait <= 1'b1;
            wait_cnt = 0;
         end
      end
   end

   // compare served reads, record served writes
   always @(posedge CLK)
   begin
      if (nRST && hit && mem_ren)
         check_word("load", load, expected_load(mem_addr));
      if (nRST && hit && mem_wen)
      begin
         shadow[word_index(mem_addr)]  = mem_store;
         written[word_index(mem_addr)] = 1'b1;
      end
   end

   initial
   begin
      #(WATCHDOG_T);
      abort_run("watchdog timeout, the cache did not finish its requests in time");
   end

   initial
   begin
      logic  quick;
      word_t rnd;
      word_t rnd_data;
      nRST      = 1'b0;
      mem_ren   = 1'b0;
      mem_wen   = 1'b0;
      halt      = 1'b0;
      mem_addr  = '0;
      mem_store = '0;
      repeat (10) @(posedge CLK);
      nRST <= 1'b1;
      @(posedge CLK);
      check_bit("mem_rd", mem_rd, 1'b0);
      check_bit("mem_wr", mem_wr, 1'b0);
      check_bit("flushed", flushed, 1'b0);
      check_bit("hit", hit, 1'b1);

      serve_request(1'b0, 32'h100, '0, quick);      // cold read miss
      check_bit("hit", quick, 1'b0);
      serve_request(1'b0, 32'h100, '0, quick);
      check_bit("hit", quick, 1'b1);
      serve_request(1'b0, 32'h104, '0, quick);      // other word of the block
      check_bit("hit", quick, 1'b1);

      serve_request(1'b1, 32'h208, 32'hdead_beef, quick);
      serve_request(1'b0, 32'h208, '0, quick);
      check_bit("hit", quick, 1'b1);
      serve_request(1'b0, 32'h20c, '0, quick);
      check_bit("hit", quick, 1'b1);
      serve_request(1'b1, 32'h104, 32'h1234_5678, quick);   // store to clean line
      check_bit("hit", quick, 1'b1);
      serve_request(1'b0, 32'h104, '0, quick);
      serve_request(1'b0, 32'h100, '0, quick);

      // three tags through set 2 force dirty evictions
      for (int r = 0; r < 3; r++)
         for (int t = 0; t < 3; t++)
            serve_request(1'b1, 32'h010 + t * 32'h40 + (r % 2) * 4,
                          32'hc0de_0000 | (r << 8) | t, quick);
      for (int t = 0; t < 3; t++)
      begin
         serve_request(1'b0, 32'h010 + t * 32'h40, '0, quick);
         serve_request(1'b0, 32'h014 + t * 32'h40, '0, quick);
      end

      for (int n = 0; n < N_RAND; n++)
      begin
         rnd      = $random(stim_seed);
         rnd_data = $random(stim_seed);
         serve_request(rnd[9], rnd & 32'h1fc, rnd_data, quick);
      end

      @(posedge CLK);
      halt <= 1'b1;
      while (!flushed)
         @(posedge CLK);
      repeat (5)
      begin
         @(posedge CLK);
         check_bit("flushed", flushed, 1'b1);
         check_bit("hit", hit, 1'b1);
         check_bit("mem_wr", mem_wr, 1'b0);
      end
      for (int i = 0; i < MEM_WORDS; i++)
         check_word("mem_model", mem_model[i], expected_load(word_t'(i * 4)));

      $display("Done: no errors");
      $finish;
   end

endmodule
